// ==== src/bp_pkg.sv ====
package bp_pkg;

  // word addresses and stored targets
  localparam int addr_w = 32;

  // branch key is instruction bits 31 to 8
  localparam int key_w = 24;

  localparam int btb_index_w = 10;
  localparam int btb_tag_w = 14;
  localparam int btb_depth = 1024;

  // local history table
  localparam int lht_index_w = 4;
  localparam int lht_depth = 16;
  localparam int lht_w = 4;  // history word, also the counter table index

  localparam int ctr_w = 2;

  localparam int queue_depth = 8;
  localparam int queue_ptr_w = 3;

  // one key word, read as tag/index by the buffer and by its low bits by the predictor
  typedef union packed {
    struct packed {
      logic [btb_tag_w-1:0]   tag;
      logic [btb_index_w-1:0] index;
    } btb;
    struct packed {
      logic [key_w-lht_index_w-1:0] upper;  // not used for prediction
      logic [lht_index_w-1:0]       index;
    } pred;
  } branch_key_t;

endpackage

// ==== src/bp_lookup_if.sv ====
`timescale 1ns/1ps

interface bp_lookup_if;

  logic                      en;  // one-cycle strobe
  bp_pkg::branch_key_t       key;
  logic                      is_cond;  // low for a jump
  logic                      hit;
  logic [bp_pkg::addr_w-1:0] target;
  logic                      taken_hint;

  modport requester (
    output en,
    output key,
    output is_cond,
    input  hit,
    input  target,
    input  taken_hint
  );

  modport btb (
    input  en,
    input  key,
    output hit,
    output target
  );

  modport predictor (
    input  en,
    input  key,
    output taken_hint
  );

endinterface

// ==== src/bp_update_if.sv ====
`timescale 1ns/1ps

interface bp_update_if;

  // resolved branch, popped from the queue
  logic                      en;
  bp_pkg::branch_key_t       key;
  logic                      is_cond;
  logic                      taken;
  logic [bp_pkg::addr_w-1:0] target;

  modport source (
    output en,
    output key,
    output is_cond,
    output taken,
    output target
  );

  modport btb (
    input en,
    input key,
    input taken,
    input target
  );

  modport predictor (
    input en,
    input key,
    input is_cond,
    input taken
  );

endinterface

// ==== src/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer (
  input logic      clk,
  input logic      rst,
  bp_lookup_if.btb lookup,
  bp_update_if.btb update
);

  logic [bp_pkg::btb_depth-1:0]   valid_q;
  logic [bp_pkg::btb_tag_w-1:0]   tag_mem [bp_pkg::btb_depth];
  logic [bp_pkg::addr_w-1:0]      target_mem [bp_pkg::btb_depth];
  logic [bp_pkg::btb_index_w-1:0] rd_idx;
  logic [bp_pkg::btb_index_w-1:0] wr_idx;
  logic                           wr_en;
  logic                           tag_match;

  assign rd_idx = lookup.key.btb.index;
  assign wr_idx = update.key.btb.index;

  // only taken outcomes allocate, not-taken leaves the entry alone
  assign wr_en = update.en & update.taken;

  assign tag_match = tag_mem[rd_idx] == lookup.key.btb.tag;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
      lookup.hit <= 1'b0;
    end
    else
    begin
      if (wr_en)
      begin
        valid_q[wr_idx] <= 1'b1;
      end
      if (lookup.en)
      begin
        lookup.hit <= valid_q[rd_idx] & tag_match;  // old contents on a same-cycle write
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx] <= update.key.btb.tag;  // aliasing entry is simply replaced
      target_mem[wr_idx] <= update.target;
    end
    if (lookup.en)
    begin
      lookup.target <= target_mem[rd_idx];
    end
  end

  // a hit must come from an entry that was written by an earlier resolve
  hit_target_known: assert property (
    @(posedge clk) disable iff (rst)
    lookup.hit |-> !$isunknown(lookup.target)
  ) else $error("branch_target_buffer: hit with unknown target");

endmodule

// ==== src/local_history_predictor.sv ====
`timescale 1ns/1ps

module local_history_predictor (
  input logic            clk,
  input logic            rst,
  bp_lookup_if.predictor lookup,
  bp_update_if.predictor update
);

  logic [bp_pkg::lht_w-1:0] hist_q [bp_pkg::lht_depth];
  logic [bp_pkg::ctr_w-1:0] ctr_q [2**bp_pkg::lht_w];  // indexed by history word

  logic [bp_pkg::lht_w-1:0] look_hist;
  logic [bp_pkg::lht_w-1:0] upd_hist;
  logic [bp_pkg::ctr_w-1:0] upd_ctr;
  logic [bp_pkg::ctr_w-1:0] ctr_next;
  logic                     upd_fire;

  assign look_hist = hist_q[lookup.key.pred.index];
  assign upd_hist = hist_q[update.key.pred.index];
  assign upd_ctr = ctr_q[upd_hist];

  // jumps do not train the counters
  assign upd_fire = update.en & update.is_cond;

  // saturating 2-bit counter
  always_comb
  begin
    ctr_next = upd_ctr;
    if (update.taken && upd_ctr != '1)
    begin
      ctr_next = upd_ctr + 1'b1;
    end
    else if (!update.taken && upd_ctr != '0)
    begin
      ctr_next = upd_ctr - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < bp_pkg::lht_depth; i++)
      begin
        hist_q[i] <= '0;
      end
      for (int i = 0; i < 2**bp_pkg::lht_w; i++)
      begin
        ctr_q[i] <= '0;
      end
      lookup.taken_hint <= 1'b0;
    end
    else
    begin
      if (lookup.en)
      begin
        lookup.taken_hint <= ctr_q[look_hist][bp_pkg::ctr_w-1];  // upper bit is the guess
      end
      if (upd_fire)
      begin
        ctr_q[upd_hist] <= ctr_next;
        // newest outcome shifts in at the top
        hist_q[update.key.pred.index] <= {update.taken, upd_hist[bp_pkg::lht_w-1:1]};
      end
    end
  end

  // a trained counter never wraps past either end
  ctr_no_wrap: assert property (
    @(posedge clk) disable iff (rst)
    upd_fire |=> ($past(update.taken) ? (ctr_q[$past(upd_hist)] != '0)
                                      : (ctr_q[$past(upd_hist)] != '1))
  ) else $error("local_history_predictor: counter left its range");

endmodule

// ==== src/branch_queue.sv ====
`timescale 1ns/1ps

module branch_queue (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lookup_en,
  input  logic                      lookup_is_cond,
  input  logic                      resolve_en,
  input  logic                      resolve_taken,
  input  logic [bp_pkg::addr_w-1:0] lookup_pc,
  input  logic [bp_pkg::addr_w-1:0] resolve_target,
  input  logic [bp_pkg::key_w-1:0]  lookup_key,
  output logic                      pred_valid,
  output logic                      pred_taken,
  output logic                      redirect,
  output logic                      queue_full,
  output logic [bp_pkg::addr_w-1:0] pred_target,
  output logic [bp_pkg::addr_w-1:0] pred_next_pc,
  output logic [bp_pkg::addr_w-1:0] redirect_pc,
  bp_lookup_if.requester            lookup,
  bp_update_if.source               update
);

  // lookup issued last cycle, its answer is on the interface now
  logic                      pend_q;
  logic                      pend_cond_q;
  logic [bp_pkg::addr_w-1:0] pend_pc_q;
  bp_pkg::branch_key_t       pend_key_q;

  bp_pkg::branch_key_t       q_key [bp_pkg::queue_depth];
  logic                      q_cond [bp_pkg::queue_depth];
  logic                      q_taken [bp_pkg::queue_depth];
  logic [bp_pkg::addr_w-1:0] q_fall [bp_pkg::queue_depth];

  logic [bp_pkg::queue_ptr_w-1:0] wr_ptr;
  logic [bp_pkg::queue_ptr_w-1:0] rd_ptr;
  logic [bp_pkg::queue_ptr_w:0]   count;
  logic                           push;
  logic                           pop;
  logic                           mispredict;
  logic [bp_pkg::addr_w-1:0]      fall_through;

  assign lookup.en = lookup_en;
  assign lookup.key = lookup_key;
  assign lookup.is_cond = lookup_is_cond;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pend_q <= 1'b0;
    else
      pend_q <= lookup.en;
  end

  always_ff @(posedge clk)
  begin
    if (lookup.en)
    begin
      pend_pc_q <= lookup_pc;
      pend_key_q <= lookup.key;
      pend_cond_q <= lookup.is_cond;
    end
  end

  // jump follows the hit, conditional also needs the counter
  assign pred_valid = pend_q;
  assign pred_taken = lookup.hit & (~pend_cond_q | lookup.taken_hint);
  assign pred_target = lookup.hit ? lookup.target : '0;
  assign fall_through = pend_pc_q + 1'b1;  // word addressed
  assign pred_next_pc = pred_taken ? pred_target : fall_through;

  assign queue_full = count == (bp_pkg::queue_ptr_w + 1)'(bp_pkg::queue_depth);
  assign push = pend_q & ~queue_full;  // dropped when full
  assign pop = resolve_en & (count != '0);

  // oldest entry goes back to the tables
  assign update.en = pop;
  assign update.key = q_key[rd_ptr];
  assign update.is_cond = q_cond[rd_ptr];
  assign update.taken = resolve_taken;
  assign update.target = resolve_target;

  assign mispredict = resolve_taken != q_taken[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      q_key[wr_ptr] <= pend_key_q;
      q_cond[wr_ptr] <= pend_cond_q;
      q_taken[wr_ptr] <= pred_taken;
      q_fall[wr_ptr] <= fall_through;
    end
    if (pop)
    begin
      redirect_pc <= resolve_taken ? resolve_target : q_fall[rd_ptr];
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      redirect <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth 8
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      redirect <= pop & mispredict;  // one cycle only
    end
  end

  // the answer cycle of a lookup is when its entry gets written
  no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    pred_valid |-> !queue_full
  ) else $error("branch_queue: push while full");

  no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    resolve_en |-> count != '0
  ) else $error("branch_queue: pop while empty");

endmodule

// ==== src/branch_predict_unit.sv ====
`timescale 1ns/1ps

module branch_predict_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lookup_en,
  input  logic                      lookup_is_cond,
  input  logic                      resolve_en,
  input  logic                      resolve_taken,
  input  logic [bp_pkg::addr_w-1:0] lookup_pc,
  input  logic [bp_pkg::addr_w-1:0] resolve_target,
  input  logic [bp_pkg::key_w-1:0]  lookup_key,
  output logic                      pred_valid,
  output logic                      pred_taken,
  output logic                      redirect,
  output logic                      queue_full,
  output logic [bp_pkg::addr_w-1:0] pred_target,
  output logic [bp_pkg::addr_w-1:0] pred_next_pc,
  output logic [bp_pkg::addr_w-1:0] redirect_pc
);

  bp_lookup_if lookup_bus ();
  bp_update_if update_bus ();

  // owns the handshake, the tables only answer
  branch_queue queue_i (
    .clk            (clk),
    .rst            (rst),
    .lookup_en      (lookup_en),
    .lookup_is_cond (lookup_is_cond),
    .resolve_en     (resolve_en),
    .resolve_taken  (resolve_taken),
    .lookup_pc      (lookup_pc),
    .resolve_target (resolve_target),
    .lookup_key     (lookup_key),
    .pred_valid     (pred_valid),
    .pred_taken     (pred_taken),
    .redirect       (redirect),
    .queue_full     (queue_full),
    .pred_target    (pred_target),
    .pred_next_pc   (pred_next_pc),
    .redirect_pc    (redirect_pc),
    .lookup         (lookup_bus.requester),
    .update         (update_bus.source)
  );

  branch_target_buffer btb_i (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup_bus.btb),
    .update (update_bus.btb)
  );

  local_history_predictor predictor_i (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup_bus.predictor),
    .update (update_bus.predictor)
  );

endmodule

// ==== verif/bp_model.svh ====
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// model of the tables and the in-flight queue, included inside bp_tb
logic                         m_valid [bp_pkg::btb_depth];
logic [bp_pkg::btb_tag_w-1:0] m_tag [bp_pkg::btb_depth];
logic [bp_pkg::addr_w-1:0]    m_tgt [bp_pkg::btb_depth];
logic [bp_pkg::lht_w-1:0]     m_hist [bp_pkg::lht_depth];
logic [bp_pkg::ctr_w-1:0]     m_ctr [2**bp_pkg::lht_w];

// queue fields: key, is_cond, predicted taken, fall-through, issue cycle
bp_pkg::branch_key_t       mq_key [$];
logic                      mq_cond [$];
logic                      mq_taken [$];
logic [bp_pkg::addr_w-1:0] mq_fall [$];
int                        mq_issue [$];

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic void model_reset();
  foreach (m_valid[i]) m_valid[i] = 1'b0;
  foreach (m_hist[i]) m_hist[i] = '0;
  foreach (m_ctr[i]) m_ctr[i] = '0;
  mq_key.delete();
  mq_cond.delete();
  mq_taken.delete();
  mq_fall.delete();
  mq_issue.delete();
endfunction

function automatic logic model_hit(input bp_pkg::branch_key_t key);
  return m_valid[key.btb.index] && (m_tag[key.btb.index] == key.btb.tag);
endfunction

function automatic logic model_predict(input bp_pkg::branch_key_t key, input logic cond);
  logic [bp_pkg::ctr_w-1:0] c;
  c = m_ctr[m_hist[key.pred.index]];
  return model_hit(key) && (!cond || c[1]);
endfunction

// table update for one resolved branch
function automatic void model_train(input bp_pkg::branch_key_t key, input logic cond,
                                    input logic taken, input logic [31:0] tgt);
  logic [bp_pkg::lht_w-1:0] h;
  if (taken)
  begin
    m_valid[key.btb.index] = 1'b1;
    m_tag[key.btb.index] = key.btb.tag;
    m_tgt[key.btb.index] = tgt;
  end
  if (cond)
  begin
    h = m_hist[key.pred.index];
    if (taken && m_ctr[h] != 2'd3)
      m_ctr[h] = m_ctr[h] + 2'd1;
    else if (!taken && m_ctr[h] != 2'd0)
      m_ctr[h] = m_ctr[h] - 2'd1;
    m_hist[key.pred.index] = {taken, h[3:1]};
  end
endfunction

`endif

// ==== verif/bp_tb.sv ====
`timescale 1ns/1ps

module bp_tb;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      lookup_en;
  logic                      lookup_is_cond;
  logic                      resolve_en;
  logic                      resolve_taken;
  logic [bp_pkg::addr_w-1:0] lookup_pc;
  logic [bp_pkg::addr_w-1:0] resolve_target;
  logic [bp_pkg::key_w-1:0]  lookup_key;
  logic                      pred_valid;
  logic                      pred_taken;
  logic                      redirect;
  logic                      queue_full;
  logic [bp_pkg::addr_w-1:0] pred_target;
  logic [bp_pkg::addr_w-1:0] pred_next_pc;
  logic [bp_pkg::addr_w-1:0] redirect_pc;

  `include "bp_model.svh"

  logic [31:0] seed = 32'd57364;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          t0;
  logic        exp_pv = 1'b0;
  logic        exp_pt;
  logic        exp_redir = 1'b0;
  logic [31:0] exp_ptgt;
  logic [31:0] exp_pnext;
  logic [31:0] exp_rpc;
  bp_pkg::branch_key_t key_a;
  bp_pkg::branch_key_t key_b;

  branch_predict_unit branch_predict_unit_i (.*);

  always #5 clk = ~clk;

  function automatic int unsigned rnd(input int unsigned n);
    seed = lcg_next(seed);
    return seed[30:16] % n;
  endfunction

  // few tags over indices that alias in both tables
  function automatic bp_pkg::branch_key_t pick_key();
    bp_pkg::branch_key_t k;
    int unsigned idx [4] = '{5, 21, 37, 300};
    k.btb.tag = 14'(rnd(3) + 1);
    k.btb.index = 10'(idx[rnd(4)]);
    return k;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [bp_pkg::addr_w-1:0] exp,
                            input logic [bp_pkg::addr_w-1:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_key(input string name, input bp_pkg::branch_key_t exp,
                           input bp_pkg::branch_key_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // checks last cycle's results then updates the model and drives one cycle
  task automatic step(input logic lk, input bp_pkg::branch_key_t key, input logic cond,
                      input logic [31:0] pc, input logic rs, input logic rtaken,
                      input logic [31:0] rtgt);
    int committed;
    committed = 0;
    foreach (mq_issue[i])
      if (mq_issue[i] <= cyc - 2)
        committed++;  // pushed at end of the answer cycle
    check_bit("pred_valid", exp_pv, pred_valid);
    if (exp_pv)
    begin
      check_bit("pred_taken", exp_pt, pred_taken);
      check_word("pred_target", exp_ptgt, pred_target);
      check_word("pred_next_pc", exp_pnext, pred_next_pc);
    end
    check_bit("redirect", exp_redir, redirect);
    if (exp_redir)
      check_word("redirect_pc", exp_rpc, redirect_pc);
    check_bit("queue_full", committed == 8, queue_full);
    exp_pv = lk;
    exp_redir = 1'b0;
    if (lk)
    begin
      exp_pt = model_predict(key, cond);  // tables before this cycle's resolve
      exp_ptgt = model_hit(key) ? m_tgt[key.btb.index] : 32'd0;
      exp_pnext = exp_pt ? exp_ptgt : pc + 32'd1;
    end
    if (rs)
    begin
      check_key("update_key", mq_key[0], branch_predict_unit_i.update_bus.key);
      exp_redir = rtaken != mq_taken[0];
      exp_rpc = rtaken ? rtgt : mq_fall[0];
      model_train(mq_key[0], mq_cond[0], rtaken, rtgt);
      void'(mq_key.pop_front());
      void'(mq_cond.pop_front());
      void'(mq_taken.pop_front());
      void'(mq_fall.pop_front());
      void'(mq_issue.pop_front());
    end
    if (lk)
    begin
      mq_key.push_back(key);
      mq_cond.push_back(cond);
      mq_taken.push_back(exp_pt);
      mq_fall.push_back(pc + 32'd1);
      mq_issue.push_back(cyc);
    end
    lookup_en = lk;
    lookup_key = key;
    lookup_is_cond = cond;
    lookup_pc = pc;
    resolve_en = rs;
    resolve_taken = rtaken;
    resolve_target = rtgt;
    @(negedge clk);
    cyc++;
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, 32'd0, 1'b0, 1'b0, 32'd0);
  endtask

  task automatic lookup(input bp_pkg::branch_key_t key, input logic cond);
    if (mq_key.size() >= bp_pkg::queue_depth)
    begin
      errors++;
      $display("lookup refused at %0t, queue already holds every branch in flight", $time);
    end
    else
      step(1'b1, key, cond, 32'(rnd(32768)) << 2, 1'b0, 1'b0, 32'd0);
  endtask

  function automatic logic can_resolve();
    return mq_issue.size() > 0 && mq_issue[0] <= cyc - 2;
  endfunction

  // how selects the outcome as 0 the given taken, 1 opposite of the prediction or 2 the prediction
  task automatic resolve(input int how, input logic taken, input logic [31:0] tgt);
    int t;
    t = 0;
    while (!can_resolve() && t < 20)
    begin
      idle();
      t++;
    end
    if (!can_resolve())
    begin
      errors++;
      $display("resolve timed out, no branch in flight at %0t", $time);
    end
    else
    begin
      if (how == 1)
        taken = !mq_taken[0];
      else if (how == 2)
        taken = mq_taken[0];
      step(1'b0, '0, 1'b0, 32'd0, 1'b1, taken, tgt);
    end
  endtask

  // new lookup sees the tables as they were before the same-cycle resolve
  task automatic lookup_and_resolve();
    bp_pkg::branch_key_t key;
    logic                cond;
    logic [31:0]         pc;
    logic                taken;
    logic [31:0]         tgt;
    key = pick_key();
    cond = rnd(2) == 1;
    pc = 32'(rnd(32768)) << 2;
    taken = rnd(2) == 1;
    tgt = 32'(rnd(65536));
    step(1'b1, key, cond, pc, 1'b1, taken, tgt);
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (mq_key.size() > 0 && t < 40)
    begin
      resolve(0, rnd(2) == 1, 32'(rnd(65536)));
      t++;
    end
    idle();
    idle();
  endtask

  task automatic report(input string name, input int start_errs);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - start_errs);
  endtask

  initial
  begin
    #2ms;
    $display("watchdog expired, simulation did not finish");
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    rst = 1'b1;
    lookup_en = 1'b0;
    lookup_is_cond = 1'b0;
    lookup_pc = '0;
    lookup_key = '0;
    resolve_en = 1'b0;
    resolve_taken = 1'b0;
    resolve_target = '0;
    model_reset();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    t0 = errors;
    repeat (6) lookup(pick_key(), rnd(2) == 1);
    drain();
    report("reset lookups miss", t0);

    t0 = errors;
    key_a = '0;
    key_a.btb.tag = 14'd1;
    key_a.btb.index = 10'd300;
    key_b = key_a;
    key_b.btb.tag = 14'd2;
    lookup(key_a, 1'b0);
    resolve(0, 1'b1, 32'h1000);
    lookup(key_a, 1'b0);  // hits now
    resolve(0, 1'b1, 32'h1000);
    lookup(key_b, 1'b0);  // same index with another tag
    resolve(0, 1'b1, 32'h2000);
    lookup(key_a, 1'b0);  // replaced by key_b
    drain();
    report("target buffer alias", t0);

    t0 = errors;
    repeat (100)
    begin
      lookup(pick_key(), 1'b1);
      resolve(0, rnd(4) == 0, 32'(rnd(65536)));  // mostly not taken so counters pin at zero
    end
    repeat (100)
    begin
      lookup(pick_key(), 1'b1);
      resolve(0, rnd(4) != 0, 32'(rnd(65536)));  // mostly taken so counters pin at three
    end
    drain();
    report("counter training", t0);

    t0 = errors;
    repeat (20)
    begin
      lookup(pick_key(), rnd(2) == 1);
      resolve(1, 1'b0, 32'(rnd(65536)));
      lookup(pick_key(), rnd(2) == 1);
      resolve(2, 1'b0, 32'(rnd(65536)));
    end
    drain();
    report("redirect", t0);

    t0 = errors;
    repeat (8) lookup(pick_key(), rnd(2) == 1);
    idle();
    idle();
    check_bit("queue_full", 1'b1, queue_full);
    resolve(0, 1'b0, 32'd0);
    idle();
    check_bit("queue_full", 1'b0, queue_full);
    drain();
    report("queue order and full", t0);

    t0 = errors;
    repeat (400)
    begin
      case (rnd(4))
        0:
          if (mq_key.size() < 8)
            lookup(pick_key(), rnd(2) == 1);
          else
            idle();
        1:
          if (can_resolve())
            resolve(0, rnd(2) == 1, 32'(rnd(65536)));
          else
            idle();
        2:
          if (mq_key.size() < 8 && can_resolve())
            lookup_and_resolve();
          else
            idle();
        default:
          idle();
      endcase
    end
    drain();
    report("random mix", t0);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verif
src/bp_pkg.sv
src/bp_lookup_if.sv
src/bp_update_if.sv
src/branch_target_buffer.sv
src/local_history_predictor.sv
src/branch_queue.sv
src/branch_predict_unit.sv
verif/bp_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module bp_tb -o bp_sim

out=$(./obj_dir/bp_sim)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -q -F '*** PASSED ***'
